/* tests/clint_trace.txt */
# op addr wdata expect id  (all hex)
# wr: expect is sw_int after b, rd: expect is rdata, tmr_le: wdata is the offset, tmr_ge: expect is the cycle limit
rd 800000 0 0 1
wr 800000 1 1 2
rd 800000 0 1 3
wr 804000 123456789abcdef0 1 4
rd 804000 0 123456789abcdef0 5
wr 800000 2 0 6
rd 800000 0 0 7
wr 800000 ffffffffffffffff 1 8
rd 900000 0 0 9
wr 900000 dead 1 a
rd 800000 0 1 b
rd 804000 0 123456789abcdef0 c
rd 80bff8 0 0 d
rd 80bff8 0 0 e
rdhi_zero 80bffc 0 0 f
wr 804000 0 1 0
tmr_ge 0 0 1 1
tmr_le 804000 c8 1 2
tmr_ge 0 0 12c 3
wr 800000 0 0 4
rd 800000 0 0 5

/* all.f */
+incdir+design
design/clint_pkg.sv
design/clint_wr_fsm.sv
design/clint_mtime.sv
design/clint_regs.sv
design/clint_resp_slot.sv
design/clint_top.sv
tests/clint_props.sv
tests/tb_clint.sv

/* run_sim.sh */
#!/bin/sh
# build and run the clint testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_clint -o sim_clint

./obj_dir/sim_clint > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

/* tests/tb_clint.sv */
/*
 * trace-driven testbench for the clint slave, with random aw/w order
 * and random response back-pressure
 */

`timescale 1ns/100ps
`include "clint_cfg.svh"

module tb_clint;

  logic clk, rst_to_orv64;
  logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
  logic b_valid, b_ready, r_valid, r_ready, sw_int, timer_int;
  clint_pkg::sysbus_aw_t aw;
  clint_pkg::sysbus_w_t  w;
  clint_pkg::sysbus_ar_t ar;
  clint_pkg::sysbus_b_t  b;
  clint_pkg::sysbus_r_t  r;

  string       t_op[$];
  logic [63:0] t_addr[$], t_data[$], t_exp[$], t_id[$];
  int          n_ops = 0;
  logic [31:0] lfsr = 32'hb453_9b44;
  logic [63:0] last_mtime = '0;

  clint_top u_clint_top (.*);

  bind clint_top clint_props u_props (.*);

  always #2 clk = ~clk;

  // --------------------
  // helpers
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int k, output int v);
    v = 0;
    for (int i = 0; i < k; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_b(input clint_pkg::sysbus_b_t exp, input clint_pkg::sysbus_b_t got);
    if (got !== exp) begin
      $display("ERROR %0t b.bid expected %h got %h", $time, exp.bid, got.bid);
      stop_run();
    end
  endtask

  // rdata only compared when the trace knows it
  task automatic check_r(input clint_pkg::sysbus_r_t exp, input clint_pkg::sysbus_r_t got,
                         input logic data_known);
    if (got.rid !== exp.rid) begin
      $display("ERROR %0t r.rid expected %h got %h", $time, exp.rid, got.rid);
      stop_run();
    end
    if (data_known && (got.rdata !== exp.rdata)) begin
      $display("ERROR %0t r.rdata expected %h got %h", $time, exp.rdata, got.rdata);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERROR %0t %s expected %b got %b", $time, name, exp, got);
      stop_run();
    end
  endtask

  // --------------------
  // bus masters driven on the falling edge
  task automatic do_write(input logic [63:0] addr, input logic [63:0] data,
                          input logic [63:0] id, input logic exp_sw);
    int mode, gap, hold;
    logic aw_done, w_done, fired;
    clint_pkg::sysbus_b_t exp_b;
    draw_bits(2, mode);
    draw_bits(2, gap);
    repeat (gap) @(negedge clk);
    aw.awid = id[3:0];
    aw.awaddr = addr[39:0];
    w.wdata = data;
    aw_done = 1'b0;
    w_done = 1'b0;
    // mode 1 sends aw first and mode 2 sends w first
    // any other mode sends both together
    aw_valid = (mode != 2);
    w_valid = (mode != 1);
    while (!(aw_done && w_done)) begin
      #1;
      if (aw_valid && aw_ready) aw_done = 1'b1;
      if (w_valid && w_ready) w_done = 1'b1;
      @(negedge clk);
      aw_valid = !aw_done;
      w_valid = !w_done;
    end
    // b is up right after the accepting edge
    check_level("b_valid", 1'b1, b_valid);
    exp_b.bid = id[3:0];
    draw_bits(3, hold);
    repeat (hold) @(negedge clk);
    b_ready = 1'b1;
    do begin
      #1;
      fired = b_valid;
      if (fired) check_b(exp_b, b);
      @(negedge clk);
    end while (!fired);
    b_ready = 1'b0;
    // exactly one response per write
    check_level("b_valid", 1'b0, b_valid);
    check_level("sw_int", exp_sw, sw_int);
  endtask

  task automatic do_read(input logic [63:0] addr, input logic [63:0] id,
                         input logic [63:0] exp, input logic data_known,
                         output logic [63:0] rdata);
    int gap, hold;
    logic fired;
    clint_pkg::sysbus_r_t exp_r;
    draw_bits(2, gap);
    repeat (gap) @(negedge clk);
    ar.arid = id[3:0];
    ar.araddr = addr[39:0];
    ar_valid = 1'b1;
    // the r slot is empty here and a pending write must not hold ar off
    #1;
    check_level("ar_ready", 1'b1, ar_ready);
    @(negedge clk);
    ar_valid = 1'b0;
    check_level("r_valid", 1'b1, r_valid);
    exp_r.rid = id[3:0];
    exp_r.rdata = exp;
    draw_bits(3, hold);
    repeat (hold) @(negedge clk);
    r_ready = 1'b1;
    do begin
      #1;
      fired = r_valid;
      if (fired) begin
        check_r(exp_r, r, data_known);
        rdata = r.rdata;
      end
      @(negedge clk);
    end while (!fired);
    r_ready = 1'b0;
    // exactly one response per read
    check_level("r_valid", 1'b0, r_valid);
  endtask

  // mtime only has to move forward
  task automatic read_mtime(input logic [63:0] id, output logic [63:0] t);
    do_read(64'(`CLINT_MTIME_OFS), id, '0, 1'b0, t);
    if (t <= last_mtime) begin
      $display("ERROR %0t r.rdata expected above %h got %h", $time, last_mtime, t);
      stop_run();
    end
    last_mtime = t;
  endtask

  task automatic load_trace();
    int fd, cnt;
    string line, op;
    logic [63:0] a, d, e, i;
    fd = $fopen("tests/clint_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      stop_run();
    end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (line.len() > 0 && line.substr(0, 0) != "#") begin
        cnt = $sscanf(line, "%s %h %h %h %h", op, a, d, e, i);
        if (cnt == 5) begin
          t_op.push_back(op);
          t_addr.push_back(a);
          t_data.push_back(d);
          t_exp.push_back(e);
          t_id.push_back(i);
        end
      end
    end
    $fclose(fd);
    n_ops = t_op.size();
    if (n_ops == 0) begin
      $display("the trace file holds no operations");
      stop_run();
    end
  endtask

  // --------------------
  // watchdog allows 64 cycles per trace line
  initial begin
    wait (n_ops > 0);
    repeat (n_ops * 64) @(posedge clk);
    $display("bus hung: the trace did not finish in its cycle budget");
    stop_run();
  end

  initial begin
    logic [63:0] t, cnt;
    clk = 1'b0;
    rst_to_orv64 = 1'b1;
    aw_valid = 1'b0;
    w_valid = 1'b0;
    ar_valid = 1'b0;
    b_ready = 1'b0;
    r_ready = 1'b0;
    aw = '0;
    w = '0;
    ar = '0;
    load_trace();
    repeat (4) @(negedge clk);
    rst_to_orv64 = 1'b0;
    check_level("timer_int", 1'b0, timer_int);
    check_level("sw_int", 1'b0, sw_int);
    check_level("aw_ready", 1'b1, aw_ready);
    check_level("w_ready", 1'b1, w_ready);
    check_level("ar_ready", 1'b1, ar_ready);
    for (int k = 0; k < n_ops; k++) begin
      case (t_op[k])
        "wr": begin
          // a write and a read of another register run side by side
          if (k + 1 < n_ops && t_op[k + 1] == "rd" && t_addr[k + 1] != t_addr[k] &&
              t_addr[k + 1] != 64'(`CLINT_MTIME_OFS)) begin
            fork
              do_write(t_addr[k], t_data[k], t_id[k], t_exp[k][0]);
              do_read(t_addr[k + 1], t_id[k + 1], t_exp[k + 1], 1'b1, t);
            join
            k++;
          end else begin
            do_write(t_addr[k], t_data[k], t_id[k], t_exp[k][0]);
          end
        end
        "rd": begin
          if (t_addr[k] == 64'(`CLINT_MTIME_OFS)) read_mtime(t_id[k], t);
          else do_read(t_addr[k], t_id[k], t_exp[k], 1'b1, t);
        end
        "rdhi_zero": do_read(t_addr[k], t_id[k], '0, 1'b1, t);
        "tmr_le": begin
          // compare point set a fixed distance ahead of now
          read_mtime(t_id[k], t);
          do_write(t_addr[k], t + t_data[k], t_id[k], t_exp[k][0]);
          check_level("timer_int", 1'b0, timer_int);
        end
        "tmr_ge": begin
          cnt = '0;
          while (!timer_int && cnt < t_exp[k]) begin
            @(negedge clk);
            cnt++;
          end
          check_level("timer_int", 1'b1, timer_int);
        end
        default: begin
          $display("unknown operation %s in the trace", t_op[k]);
          stop_run();
        end
      endcase
    end
    repeat (2) @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* tests/clint_props.sv */
/*
 * bound checks on the clint bus handshakes and reset state
 */

`timescale 1ns/100ps

module clint_props (
  input logic                  clk,
  input logic                  rst_to_orv64,
  input logic                  aw_valid,
  input logic                  aw_ready,
  input clint_pkg::sysbus_aw_t aw,
  input logic                  w_valid,
  input logic                  w_ready,
  input clint_pkg::sysbus_w_t  w,
  input logic                  ar_valid,
  input logic                  ar_ready,
  input clint_pkg::sysbus_ar_t ar,
  input logic                  b_valid,
  input logic                  b_ready,
  input clint_pkg::sysbus_b_t  b,
  input logic                  r_valid,
  input logic                  r_ready,
  input clint_pkg::sysbus_r_t  r
);

  // --------------------
  // valid and payload held until the transfer
  aw_hold: assert property (@(posedge clk) disable iff (rst_to_orv64)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw)) else $error("aw dropped before ready");
  w_hold: assert property (@(posedge clk) disable iff (rst_to_orv64)
    w_valid && !w_ready |=> w_valid && $stable(w)) else $error("w dropped before ready");
  ar_hold: assert property (@(posedge clk) disable iff (rst_to_orv64)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar)) else $error("ar dropped before ready");
  b_hold: assert property (@(posedge clk) disable iff (rst_to_orv64)
    b_valid && !b_ready |=> b_valid && $stable(b)) else $error("b dropped before ready");
  r_hold: assert property (@(posedge clk) disable iff (rst_to_orv64)
    r_valid && !r_ready |=> r_valid && $stable(r)) else $error("r dropped before ready");

  // new writes wait while b is pending
  aw_blocked: assert property (@(posedge clk) disable iff (rst_to_orv64)
    b_valid |-> !aw_ready && !w_ready) else $error("write ready high with b pending");

  resp_reset: assert property (@(posedge clk)
    rst_to_orv64 |=> !b_valid && !r_valid) else $error("response valid after reset");

endmodule

/* design/clint_top.sv */
/*
 * core-local interrupt and timer slave on the system bus
 */

`timescale 1ns/100ps
`include "clint_cfg.svh"

module clint_top (
  input  logic                  clk,
  input  logic                  rst_to_orv64,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  clint_pkg::sysbus_aw_t aw,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  clint_pkg::sysbus_w_t  w,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  clint_pkg::sysbus_ar_t ar,
  output logic                  b_valid,
  input  logic                  b_ready,
  output clint_pkg::sysbus_b_t  b,
  output logic                  r_valid,
  input  logic                  r_ready,
  output clint_pkg::sysbus_r_t  r,
  output logic                  sw_int,
  output logic                  timer_int
);

  logic                     wr_commit;
  clint_pkg::clint_wr_cmd_t wr_cmd;
  logic                     b_load, b_busy, r_busy;
  clint_pkg::sysbus_b_t     b_load_data;
  clint_pkg::sysbus_r_t     r_load_data;
  logic [`CLINT_DATA_W-1:0] mtime, mtimecmp, rdata;

  // --------------------
  // write path
  clint_wr_fsm u_wr_fsm (
    .clk, .rst_to_orv64, .aw_valid, .aw, .w_valid, .w,
    .b_slot_busy(b_busy), .aw_ready, .w_ready, .wr_commit, .wr_cmd,
    .b_load, .b_load_data
  );

  clint_mtime u_mtime (
    .clk, .rst_to_orv64, .wr_commit, .wr_cmd, .mtime, .mtimecmp, .timer_int
  );

  clint_regs u_regs (
    .clk, .rst_to_orv64, .wr_commit, .wr_cmd, .ar, .mtime, .mtimecmp,
    .sw_int, .rdata
  );

  clint_resp_slot #(.payload_t(clint_pkg::sysbus_b_t)) u_b_slot (
    .clk, .rst_to_orv64, .load(b_load), .load_data(b_load_data),
    .ready(b_ready), .valid(b_valid), .data(b), .busy(b_busy)
  );

  // --------------------
  // read path, data sampled at the ar edge
  assign ar_ready = ~r_busy;
  assign r_load_data.rid = ar.arid;
  assign r_load_data.rdata = rdata;

  clint_resp_slot #(.payload_t(clint_pkg::sysbus_r_t)) u_r_slot (
    .clk, .rst_to_orv64, .load(ar_valid & ar_ready), .load_data(r_load_data),
    .ready(r_ready), .valid(r_valid), .data(r), .busy(r_busy)
  );

endmodule

/* design/clint_resp_slot.sv */
/*
 * one-entry response holder, shared by the b and r channels
 */

`timescale 1ns/100ps

module clint_resp_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_to_orv64,
  input  logic     load,
  input  payload_t load_data,
  input  logic     ready,
  output logic     valid,
  output payload_t data,
  output logic     busy
);

  // load only arrives while empty, producers gate on busy
  always_ff @(posedge clk) begin
    if (rst_to_orv64) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (valid && ready) begin
      valid <= 1'b0;
    end
  end

  // held stable until the transfer
  always_ff @(posedge clk) begin
    if (load) data <= load_data;
  end

  assign busy = valid;

endmodule

/* design/clint_regs.sv */
/*
 * msip register, write decode and read data mux
 */

`timescale 1ns/100ps
`include "clint_cfg.svh"

module clint_regs (
  input  logic                     clk,
  input  logic                     rst_to_orv64,
  input  logic                     wr_commit,
  input  clint_pkg::clint_wr_cmd_t wr_cmd,
  input  clint_pkg::sysbus_ar_t    ar,
  input  logic [`CLINT_DATA_W-1:0] mtime,
  input  logic [`CLINT_DATA_W-1:0] mtimecmp,
  output logic                     sw_int,
  output logic [`CLINT_DATA_W-1:0] rdata
);

  logic msip;

  // only bit 0 is kept
  always_ff @(posedge clk) begin
    if (rst_to_orv64) begin
      msip <= 1'b0;
    end else if (wr_commit && (wr_cmd.addr == `CLINT_MSIP_OFS)) begin
      msip <= wr_cmd.data[0];
    end
  end

  assign sw_int = msip;

  // --------------------
  // read decode, unmapped reads return zero
  always_comb begin
    case (ar.araddr)
      `CLINT_MSIP_OFS: rdata = {{(`CLINT_DATA_W-1){1'b0}}, msip};
      `CLINT_MTIMECMP_OFS: rdata = mtimecmp;
      `CLINT_MTIME_OFS: rdata = mtime;
      `CLINT_MTIMEH_OFS: begin
        rdata = {{(`CLINT_DATA_W/2){1'b0}}, mtime[`CLINT_DATA_W-1:`CLINT_DATA_W/2]};
      end
      default: rdata = '0;
    endcase
  end

endmodule

/* design/clint_mtime.sv */
/*
 * machine timer: free-running mtime, mtimecmp and the timer interrupt
 */

`timescale 1ns/100ps
`include "clint_cfg.svh"

module clint_mtime (
  input  logic                     clk,
  input  logic                     rst_to_orv64,
  input  logic                     wr_commit,
  input  clint_pkg::clint_wr_cmd_t wr_cmd,
  output logic [`CLINT_DATA_W-1:0] mtime,
  output logic [`CLINT_DATA_W-1:0] mtimecmp,
  output logic                     timer_int
);

  // counts every cycle, bus traffic or not
  always_ff @(posedge clk) begin
    if (rst_to_orv64) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + `CLINT_DATA_W'(1);
    end
  end

  // full 64-bit replace, no strobes
  always_ff @(posedge clk) begin
    if (rst_to_orv64) begin
      mtimecmp <= `CLINT_MTIMECMP_RST;
    end else if (wr_commit && (wr_cmd.addr == `CLINT_MTIMECMP_OFS)) begin
      mtimecmp <= wr_cmd.data;
    end
  end

  // unsigned compare, level stays up until mtimecmp moves ahead
  assign timer_int = (mtime >= mtimecmp);

endmodule

/* design/clint_wr_fsm.sv */
/*
 * write join FSM: takes aw and w in any order, commits the write
 * and holds off new writes until the b response has left
 */

`timescale 1ns/100ps

module clint_wr_fsm (
  input  logic                     clk,
  input  logic                     rst_to_orv64,
  input  logic                     aw_valid,
  input  clint_pkg::sysbus_aw_t    aw,
  input  logic                     w_valid,
  input  clint_pkg::sysbus_w_t     w,
  input  logic                     b_slot_busy,
  output logic                     aw_ready,
  output logic                     w_ready,
  output logic                     wr_commit,
  output clint_pkg::clint_wr_cmd_t wr_cmd,
  output logic                     b_load,
  output clint_pkg::sysbus_b_t     b_load_data
);

  clint_pkg::wr_state_e state, state_nxt;
  clint_pkg::sysbus_aw_t aw_q;
  clint_pkg::sysbus_w_t  w_q;
  logic aw_fire, w_fire;

  // each channel is open until its half of the write is held
  assign aw_ready = (state == clint_pkg::wr_idle) || (state == clint_pkg::wr_have_w);
  assign w_ready  = (state == clint_pkg::wr_idle) || (state == clint_pkg::wr_have_aw);
  assign aw_fire  = aw_valid & aw_ready;
  assign w_fire   = w_valid & w_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      clint_pkg::wr_idle: begin
        if (aw_fire && w_fire) state_nxt = clint_pkg::wr_resp;
        else if (aw_fire) state_nxt = clint_pkg::wr_have_aw;
        else if (w_fire) state_nxt = clint_pkg::wr_have_w;
      end
      clint_pkg::wr_have_aw: if (w_fire) state_nxt = clint_pkg::wr_resp;
      clint_pkg::wr_have_w: if (aw_fire) state_nxt = clint_pkg::wr_resp;
      // b slot is already full on the first cycle here
      clint_pkg::wr_resp: if (!b_slot_busy) state_nxt = clint_pkg::wr_idle;
      default: state_nxt = clint_pkg::wr_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_to_orv64) begin
      state <= clint_pkg::wr_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // --------------------
  // early half of the write
  always_ff @(posedge clk) begin
    if (aw_fire) aw_q <= aw;
    if (w_fire) w_q <= w;
  end

  // commit on the edge where the second half arrives
  assign wr_commit = (state != clint_pkg::wr_resp) && (state_nxt == clint_pkg::wr_resp);
  assign b_load    = wr_commit;

  // the late half comes straight from the bus
  assign wr_cmd.addr = (state == clint_pkg::wr_have_aw) ? aw_q.awaddr : aw.awaddr;
  assign wr_cmd.data = (state == clint_pkg::wr_have_w) ? w_q.wdata : w.wdata;
  assign b_load_data.bid = (state == clint_pkg::wr_have_aw) ? aw_q.awid : aw.awid;

endmodule

/* design/clint_pkg.sv */
/*
 * clint types: system bus channel payloads, write-join states
 * and the committed write command
 */

`include "clint_cfg.svh"

package clint_pkg;

  // --------------------
  // request channels
  typedef struct packed {
    logic [`CLINT_ID_W-1:0]   awid;
    logic [`CLINT_ADDR_W-1:0] awaddr;
  } sysbus_aw_t;

  typedef struct packed {
    logic [`CLINT_ID_W-1:0]   arid;
    logic [`CLINT_ADDR_W-1:0] araddr;
  } sysbus_ar_t;

  typedef struct packed {
    logic [`CLINT_DATA_W-1:0] wdata;
  } sysbus_w_t;

  // --------------------
  // response channels
  typedef struct packed {
    logic [`CLINT_ID_W-1:0] bid;
  } sysbus_b_t;

  typedef struct packed {
    logic [`CLINT_ID_W-1:0]   rid;
    logic [`CLINT_DATA_W-1:0] rdata;
  } sysbus_r_t;

  // write join: which half of the write has been seen
  typedef enum logic [1:0] {
    wr_idle,
    wr_have_aw,
    wr_have_w,
    wr_resp
  } wr_state_e;

  // address and data of a write, handed to the registers
  typedef struct packed {
    logic [`CLINT_ADDR_W-1:0] addr;
    logic [`CLINT_DATA_W-1:0] data;
  } clint_wr_cmd_t;

endpackage

/* design/clint_cfg.svh */
/*
 * clint configuration: bus widths, register offsets and reset values
 */

`ifndef CLINT_CFG_SVH
`define CLINT_CFG_SVH

// bus widths
`define CLINT_ADDR_W 40
`define CLINT_ID_W 4
`define CLINT_DATA_W 64

// --------------------
// register map
`define CLINT_MSIP_OFS 40'h00_0080_0000
`define CLINT_MTIMECMP_OFS 40'h00_0080_4000
`define CLINT_MTIME_OFS 40'h00_0080_bff8
`define CLINT_MTIMEH_OFS 40'h00_0080_bffc

// timer compare starts out of reach
`define CLINT_MTIMECMP_RST 64'hffff_ffff_ffff_ffff

`endif
